//--- design/isa_pkg.sv
/*
 * Instruction set definitions for the in-order pipeline.
 * Holds the 16-bit instruction format, the opcodes and the
 * widths of register indices, data values and immediates.
 */
`default_nettype none

package isa_pkg;

	// Architectural register count
	localparam int NUM_REGS = 16;

	// Bit positions of the instruction fields
	localparam int OPCODE_MSB = 15;
	localparam int OPCODE_LSB = 12;
	localparam int RD_MSB     = 11;
	localparam int RD_LSB     = 8;
	localparam int RA_MSB     = 7;
	localparam int RA_LSB     = 4;
	localparam int RB_MSB     = 3;
	localparam int RB_LSB     = 0;
	// The immediate overlays the ra and rb fields
	localparam int IMM_MSB    = 7;
	localparam int IMM_LSB    = 0;

	typedef logic [15:0] instr_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] data_t;
	typedef logic [7:0]  imm_t;

	// Shifts take their amount from the low 4 bits of rb's value
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SHL = 4'd5,
		OP_SHR = 4'd6,
		OP_LI  = 4'd7
	} opcode_t;

endpackage

`default_nettype wire

//--- design/queue_pkg.sv
/*
 * Sizing of the instruction queue that sits in front of decode.
 */
`default_nettype none

package queue_pkg;

	// Number of instruction words the queue can hold
	localparam int QUEUE_DEPTH = 8;

	// Must cover QUEUE_DEPTH entries
	localparam int QUEUE_ADDR_WIDTH = 3;

	// Almost full rises once the count reaches QUEUE_DEPTH minus this value,
	// leaving the source two cycles of slack
	localparam int QUEUE_AF_THRESHOLD = 2;

endpackage

`default_nettype wire

//--- design/sram_1r1w.sv
/*
 * Storage array with one write port and one registered read port.
 * A read of the address being written returns the new value.
 */
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w #(
	parameter int WIDTH = 16,
	parameter int NUM_ENTRIES = 8,
	parameter int ADDR_WIDTH = 3
) (
	input wire clk,
	input wire [ADDR_WIDTH-1:0] rd_addr_i,
	output logic [WIDTH-1:0] rd_data_o,
	input wire [ADDR_WIDTH-1:0] wr_addr_i,
	input wire [WIDTH-1:0] wr_data_i,
	input wire wr_enable_i
);

	logic [WIDTH-1:0] mem [NUM_ENTRIES];

	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;

		// Forward the write data so a word pushed into an empty queue
		// is visible at the head right after the edge
		if (wr_enable_i && wr_addr_i == rd_addr_i)
			rd_data_o <= wr_data_i;
		else
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
/*
 * Synchronous FIFO used as the instruction queue.
 * Circular head and tail pointers with an entry count, registered
 * full, almost-full and empty flags, and a flush that empties it.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int NUM_ENTRIES = 8,
	parameter int ADDR_WIDTH = 3,
	parameter int ALMOST_FULL_THRESHOLD = 2
) (
	input wire clk,
	input wire reset,
	input wire flush_i,
	input wire enqueue_i,
	input wire [WIDTH-1:0] value_i,
	input wire dequeue_i,
	output logic [WIDTH-1:0] value_o,
	output logic full_o,
	output logic almost_full_o,
	output logic empty_o
);

	logic [ADDR_WIDTH-1:0] head_ff;
	logic [ADDR_WIDTH-1:0] head_nxt;
	logic [ADDR_WIDTH-1:0] tail_ff;
	logic [ADDR_WIDTH-1:0] tail_nxt;
	// One extra bit so the count can reach NUM_ENTRIES
	logic [ADDR_WIDTH:0] count_ff;
	logic [ADDR_WIDTH:0] count_nxt;

	// The array is read at the next head, so the word at the head is
	// already in value_o on the cycle after any pointer move
	sram_1r1w #(
		.WIDTH(WIDTH),
		.NUM_ENTRIES(NUM_ENTRIES),
		.ADDR_WIDTH(ADDR_WIDTH)
	) fifo_data (
		.clk(clk),
		.rd_addr_i(head_nxt),
		.rd_data_o(value_o),
		.wr_addr_i(tail_ff),
		.wr_data_i(value_i),
		.wr_enable_i(enqueue_i)
	);

	always_comb
	begin
		head_nxt = head_ff;
		tail_nxt = tail_ff;
		count_nxt = count_ff;

		if (flush_i)
		begin
			// Drops every queued word, including one pushed on this edge
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
		end
		else
		begin
			// Pointers wrap at the last entry, so the depth need not be a power of two
			if (enqueue_i)
				tail_nxt = (tail_ff == ADDR_WIDTH'(NUM_ENTRIES - 1)) ? '0 : tail_ff + 1'b1;

			if (dequeue_i)
				head_nxt = (head_ff == ADDR_WIDTH'(NUM_ENTRIES - 1)) ? '0 : head_ff + 1'b1;

			// A push and a pop together leave the count unchanged
			if (enqueue_i && !dequeue_i)
				count_nxt = count_ff + 1'b1;
			else if (dequeue_i && !enqueue_i)
				count_nxt = count_ff - 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head_ff <= '0;
			tail_ff <= '0;
			count_ff <= '0;
			full_o <= 1'b0;
			almost_full_o <= 1'b0;
			empty_o <= 1'b1;
		end
		else
		begin
			head_ff <= head_nxt;
			tail_ff <= tail_nxt;
			count_ff <= count_nxt;
			// Flags follow the count they will describe after this edge
			full_o <= (count_nxt == (ADDR_WIDTH + 1)'(NUM_ENTRIES));
			almost_full_o <= (count_nxt >=
				(ADDR_WIDTH + 1)'(NUM_ENTRIES - ALMOST_FULL_THRESHOLD));
			empty_o <= (count_nxt == '0);
		end
	end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
/*
 * Decode stage. Takes the word at the queue head, splits its fields,
 * reads the source registers and holds off while an older instruction
 * still owes a write to one of them.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*; (
	input wire clk,
	input wire reset,
	input wire queue_empty_i,
	input wire instr_t instr_i,
	output logic dequeue_o,
	output reg_idx_t rd_addr_a_o,
	output reg_idx_t rd_addr_b_o,
	input wire data_t rd_data_a_i,
	input wire data_t rd_data_b_i,
	input wire ex_busy_i,
	input wire reg_idx_t ex_rd_i,
	output logic dec_valid_o,
	output opcode_t dec_op_o,
	output reg_idx_t dec_rd_o,
	output data_t dec_a_o,
	output data_t dec_b_o
);

	opcode_t op;
	imm_t imm;
	logic hazard_a;
	logic hazard_b;
	logic stall;

	assign op = opcode_t'(instr_i[OPCODE_MSB:OPCODE_LSB]);
	assign imm = instr_i[IMM_MSB:IMM_LSB];
	assign rd_addr_a_o = instr_i[RA_MSB:RA_LSB];
	assign rd_addr_b_o = instr_i[RB_MSB:RB_LSB];

	// Pending writers are our own output register and the execute register.
	// The result stage writes on the edge, so the file is current after it.
	assign hazard_a = (dec_valid_o && dec_rd_o == rd_addr_a_o) ||
		(ex_busy_i && ex_rd_i == rd_addr_a_o);
	assign hazard_b = (dec_valid_o && dec_rd_o == rd_addr_b_o) ||
		(ex_busy_i && ex_rd_i == rd_addr_b_o);

	// Load immediate has no source registers and never waits
	assign stall = (op != OP_LI) && (hazard_a || hazard_b);
	assign dequeue_o = !queue_empty_i && !stall;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			dec_valid_o <= 1'b0;
		else
			dec_valid_o <= dequeue_o;
	end

	always_ff @(posedge clk)
	begin
		if (dequeue_o)
		begin
			dec_op_o <= op;
			dec_rd_o <= instr_i[RD_MSB:RD_LSB];
			dec_a_o <= rd_data_a_i;
			// Immediate goes through as operand b, zero-extended
			dec_b_o <= (op == OP_LI) ? data_t'(imm) : rd_data_b_i;
		end
	end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
/*
 * Execute stage. Runs the ALU on the decoded operands and registers
 * the result with its destination register.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*; (
	input wire clk,
	input wire reset,
	input wire dec_valid_i,
	input wire opcode_t dec_op_i,
	input wire reg_idx_t dec_rd_i,
	input wire data_t dec_a_i,
	input wire data_t dec_b_i,
	output logic ex_valid_o,
	output reg_idx_t ex_rd_o,
	output data_t ex_result_o
);

	data_t alu_result;

	always_comb
	begin
		case (dec_op_i)
			OP_ADD: alu_result = dec_a_i + dec_b_i;
			OP_SUB: alu_result = dec_a_i - dec_b_i;
			OP_AND: alu_result = dec_a_i & dec_b_i;
			OP_OR: alu_result = dec_a_i | dec_b_i;
			OP_XOR: alu_result = dec_a_i ^ dec_b_i;
			// Shift amount is the low nibble of operand b, logical in both directions
			OP_SHL: alu_result = dec_a_i << dec_b_i[3:0];
			OP_SHR: alu_result = dec_a_i >> dec_b_i[3:0];
			// Decode already placed the extended immediate in operand b
			OP_LI: alu_result = dec_b_i;
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_valid_o <= 1'b0;
		else
			ex_valid_o <= dec_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid_i)
		begin
			ex_rd_o <= dec_rd_i;
			ex_result_o <= alu_result;
		end
	end

endmodule

`default_nettype wire

//--- design/result_stage.sv
/*
 * Result stage. Owns the register file, writes back each executed
 * result and presents it as a one-cycle retire pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module result_stage import isa_pkg::*; (
	input wire clk,
	input wire reset,
	input wire ex_valid_i,
	input wire reg_idx_t ex_rd_i,
	input wire data_t ex_result_i,
	input wire reg_idx_t rd_addr_a_i,
	input wire reg_idx_t rd_addr_b_i,
	output data_t rd_data_a_o,
	output data_t rd_data_b_o,
	output logic result_valid_o,
	output reg_idx_t result_rd_o,
	output data_t result_data_o
);

	data_t regs [NUM_REGS];

	// Decode reads both operands combinationally
	assign rd_data_a_o = regs[rd_addr_a_i];
	assign rd_data_b_o = regs[rd_addr_b_i];

	// Programs start from an all-zero register file
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (ex_valid_i)
			regs[ex_rd_i] <= ex_result_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			result_valid_o <= 1'b0;
		else
			result_valid_o <= ex_valid_i;
	end

	// Retired value is shown on the same edge the register file takes it
	always_ff @(posedge clk)
	begin
		if (ex_valid_i)
		begin
			result_rd_o <= ex_rd_i;
			result_data_o <= ex_result_i;
		end
	end

endmodule

`default_nettype wire

//--- design/instr_pipe_top.sv
/*
 * Top level of the in-order instruction pipeline.
 * Queue, decode, execute and result stages in a row.
 */
`timescale 1ns/1ps
`default_nettype none

module instr_pipe_top import isa_pkg::*, queue_pkg::*; (
	input wire clk,
	input wire reset,
	input wire flush_i,
	input wire enqueue_i,
	input wire instr_t instr_i,
	output logic full_o,
	output logic almost_full_o,
	output logic result_valid_o,
	output reg_idx_t result_rd_o,
	output data_t result_data_o
);

	instr_t head_instr;
	logic queue_empty;
	logic dequeue;
	reg_idx_t rd_addr_a;
	reg_idx_t rd_addr_b;
	data_t rd_data_a;
	data_t rd_data_b;
	logic dec_valid;
	opcode_t dec_op;
	reg_idx_t dec_rd;
	data_t dec_a;
	data_t dec_b;
	logic ex_valid;
	reg_idx_t ex_rd;
	data_t ex_result;

	sync_fifo #(
		.WIDTH($bits(instr_t)),
		.NUM_ENTRIES(QUEUE_DEPTH),
		.ADDR_WIDTH(QUEUE_ADDR_WIDTH),
		.ALMOST_FULL_THRESHOLD(QUEUE_AF_THRESHOLD)
	) instr_queue (
		.clk(clk),
		.reset(reset),
		.flush_i(flush_i),
		.enqueue_i(enqueue_i),
		.value_i(instr_i),
		.dequeue_i(dequeue),
		.value_o(head_instr),
		.full_o(full_o),
		.almost_full_o(almost_full_o),
		.empty_o(queue_empty)
	);

	decode_stage decode (
		.clk(clk),
		.reset(reset),
		.queue_empty_i(queue_empty),
		.instr_i(head_instr),
		.dequeue_o(dequeue),
		.rd_addr_a_o(rd_addr_a),
		.rd_addr_b_o(rd_addr_b),
		.rd_data_a_i(rd_data_a),
		.rd_data_b_i(rd_data_b),
		// The execute register's valid marks its destination as busy
		.ex_busy_i(ex_valid),
		.ex_rd_i(ex_rd),
		.dec_valid_o(dec_valid),
		.dec_op_o(dec_op),
		.dec_rd_o(dec_rd),
		.dec_a_o(dec_a),
		.dec_b_o(dec_b)
	);

	execute_stage execute (
		.clk(clk),
		.reset(reset),
		.dec_valid_i(dec_valid),
		.dec_op_i(dec_op),
		.dec_rd_i(dec_rd),
		.dec_a_i(dec_a),
		.dec_b_i(dec_b),
		.ex_valid_o(ex_valid),
		.ex_rd_o(ex_rd),
		.ex_result_o(ex_result)
	);

	result_stage result (
		.clk(clk),
		.reset(reset),
		.ex_valid_i(ex_valid),
		.ex_rd_i(ex_rd),
		.ex_result_i(ex_result),
		.rd_addr_a_i(rd_addr_a),
		.rd_addr_b_i(rd_addr_b),
		.rd_data_a_o(rd_data_a),
		.rd_data_b_o(rd_data_b),
		.result_valid_o(result_valid_o),
		.result_rd_o(result_rd_o),
		.result_data_o(result_data_o)
	);

endmodule

`default_nettype wire

//--- tb/instr_pipe_tb.sv
/*
 * Testbench for the in-order instruction pipeline.
 * Feeds a table of instructions through the queue, honours almost full,
 * issues a flush and checks every retired result against the table.
 */
`timescale 1ns/1ps
`default_nettype none

module instr_pipe_tb import isa_pkg::*, queue_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 200;

	// How an entry is pushed: after a random gap, back to back, after the
	// pipe has drained, or back to back with a flush right after it
	typedef enum logic [1:0] {
		MODE_GAP,
		MODE_BURST,
		MODE_DRAIN,
		MODE_FLUSH
	} push_mode_t;

	typedef struct packed {
		instr_t word;
		reg_idx_t rd;
		data_t value;
		push_mode_t mode;
		logic retires;
	} entry_t;

	logic clk = 1'b0;
	logic reset;
	logic flush;
	logic enqueue;
	instr_t instr;
	logic full;
	logic almost_full;
	logic result_valid;
	reg_idx_t result_rd;
	data_t result_data;

	entry_t program_q[$];
	int exp_idx = 0;
	int retired_count = 0;
	logic af_seen = 1'b0;

	// Queue occupancy rebuilt from the strobes. A pop only shows when its
	// result retires two edges later, so the model runs two cycles behind
	logic [2:0] enq_hist = '0;
	logic [2:0] flush_hist = '0;
	logic [1:0] af_hist = '0;
	int queued = 0;

	instr_pipe_top UUT (
		.clk(clk),
		.reset(reset),
		.flush_i(flush),
		.enqueue_i(enqueue),
		.instr_i(instr),
		.full_o(full),
		.almost_full_o(almost_full),
		.result_valid_o(result_valid),
		.result_rd_o(result_rd),
		.result_data_o(result_data)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input data_t actual, input data_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s got 0x%h, expected 0x%h", $time, name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_run(input string why);
		$display("%0t ns: %s", $time, why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic void add_entry(input instr_t word, input reg_idx_t rd, input data_t value,
		input push_mode_t mode, input logic retires);
		entry_t e;
		e.word = word;
		e.rd = rd;
		e.value = value;
		e.mode = mode;
		e.retires = retires;
		program_q.push_back(e);
	endfunction

	// Expected values worked out by hand from the opcode rules
	task automatic load_program();
		// Independent loads, each immediate zero-extended
		add_entry(16'h7105, 4'd1, 16'h0005, MODE_GAP, 1'b1);
		add_entry(16'h72F0, 4'd2, 16'h00F0, MODE_GAP, 1'b1);
		add_entry(16'h7303, 4'd3, 16'h0003, MODE_GAP, 1'b1);
		add_entry(16'h74FF, 4'd4, 16'h00FF, MODE_GAP, 1'b1);
		add_entry(16'h7581, 4'd5, 16'h0081, MODE_GAP, 1'b1);
		// One of each ALU operation, shifts use the low nibble of rb's value
		add_entry(16'h0612, 4'd6, 16'h00F5, MODE_GAP, 1'b1);
		add_entry(16'h1712, 4'd7, 16'hFF15, MODE_GAP, 1'b1);
		add_entry(16'h2824, 4'd8, 16'h00F0, MODE_GAP, 1'b1);
		add_entry(16'h3912, 4'd9, 16'h00F5, MODE_GAP, 1'b1);
		add_entry(16'h4A45, 4'd10, 16'h007E, MODE_GAP, 1'b1);
		add_entry(16'h5B43, 4'd11, 16'h07F8, MODE_GAP, 1'b1);
		add_entry(16'h6C23, 4'd12, 16'h001E, MODE_GAP, 1'b1);
		add_entry(16'h5D57, 4'd13, 16'h1020, MODE_GAP, 1'b1);
		add_entry(16'h6E74, 4'd14, 16'h0001, MODE_GAP, 1'b1);
		// Back to back dependent chain
		add_entry(16'h7111, 4'd1, 16'h0011, MODE_DRAIN, 1'b1);
		add_entry(16'h0111, 4'd1, 16'h0022, MODE_BURST, 1'b1);
		add_entry(16'h0211, 4'd2, 16'h0044, MODE_BURST, 1'b1);
		add_entry(16'h1321, 4'd3, 16'h0022, MODE_BURST, 1'b1);
		add_entry(16'h4132, 4'd1, 16'h0066, MODE_BURST, 1'b1);
		add_entry(16'h5213, 4'd2, 16'h0198, MODE_BURST, 1'b1);
		// Long doubling chain, decode pops one word per three cycles so the queue fills
		add_entry(16'h7401, 4'd4, 16'h0001, MODE_DRAIN, 1'b1);
		for (int i = 1; i <= 9; i++)
			add_entry(16'h0444, 4'd4, data_t'(1 << i), MODE_BURST, 1'b1);
		add_entry(16'h6543, 4'd5, 16'h0080, MODE_BURST, 1'b1);
		// Flush lands while the third word waits on r1, so only two retire
		add_entry(16'h7101, 4'd1, 16'h0001, MODE_DRAIN, 1'b1);
		add_entry(16'h0111, 4'd1, 16'h0002, MODE_BURST, 1'b1);
		add_entry(16'h0111, 4'd1, 16'h0000, MODE_BURST, 1'b0);
		add_entry(16'h0111, 4'd1, 16'h0000, MODE_BURST, 1'b0);
		add_entry(16'h0111, 4'd1, 16'h0000, MODE_BURST, 1'b0);
		add_entry(16'h0111, 4'd1, 16'h0000, MODE_FLUSH, 1'b0);
		// Pipe works after the flush and r1 still holds the last retired value
		add_entry(16'h765A, 4'd6, 16'h005A, MODE_DRAIN, 1'b1);
		add_entry(16'h0716, 4'd7, 16'h005C, MODE_BURST, 1'b1);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		enqueue <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic wait_drained(input int need);
		int waited;
		waited = 0;
		idle_cycle();
		while (retired_count < need)
		begin
			if (waited == TIMEOUT_CYCLES)
				fail_run("Timeout while waiting for the pipeline to drain");
			waited++;
			idle_cycle();
		end
	endtask

	// Almost full is sampled at the falling edge, away from the flag update
	task automatic push_word(input instr_t word);
		int waited;
		waited = 0;
		@(negedge clk);
		while (almost_full)
		begin
			if (waited == TIMEOUT_CYCLES)
				fail_run("Timeout while the queue stayed almost full");
			waited++;
			idle_cycle();
			@(negedge clk);
		end
		@(posedge clk);
		enqueue <= 1'b1;
		instr <= word;
	endtask

	// Collects retire pulses in program order and watches the queue flags
	always @(negedge clk)
	begin
		if (!reset)
		begin
			check_value("full_o", data_t'(full), 16'h0000);
			if (almost_full)
				af_seen = 1'b1;
			// Strobes seen three negedges back were taken on the edge whose pop retires now
			if (flush_hist[2])
				queued = 0;
			else
				queued = queued + int'(enq_hist[2]) - int'(result_valid);
			// Almost full must be high exactly when six or more words are queued
			check_value("almost_full_o", data_t'(af_hist[1]),
				data_t'(queued >= QUEUE_DEPTH - QUEUE_AF_THRESHOLD));
			enq_hist = {enq_hist[1:0], enqueue};
			flush_hist = {flush_hist[1:0], flush};
			af_hist = {af_hist[0], almost_full};
			if (result_valid)
			begin
				while (exp_idx < program_q.size() && !program_q[exp_idx].retires)
					exp_idx++;
				if (exp_idx >= program_q.size())
					fail_run("A result retired that the program does not expect");
				else
				begin
					check_value("result_rd_o", data_t'(result_rd), data_t'(program_q[exp_idx].rd));
					check_value("result_data_o", result_data, program_q[exp_idx].value);
					exp_idx++;
					retired_count++;
				end
			end
		end
	end

	initial
	begin
		int unsigned first_draw;
		int issued;
		issued = 0;
		reset = 1'b1;
		flush = 1'b0;
		enqueue = 1'b0;
		instr = '0;
		first_draw = $urandom(32'ha189);
		load_program();

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < program_q.size(); i++)
		begin
			if (program_q[i].mode == MODE_GAP)
				repeat ($urandom % 4) idle_cycle();
			else if (program_q[i].mode == MODE_DRAIN)
				wait_drained(issued);
			push_word(program_q[i].word);
			if (program_q[i].retires)
				issued++;
			// The flush strobe follows the last word of the burst directly
			if (program_q[i].mode == MODE_FLUSH)
			begin
				@(posedge clk);
				enqueue <= 1'b0;
				flush <= 1'b1;
				idle_cycle();
			end
		end

		wait_drained(issued);
		// A few quiet cycles catch any stray pulse from a flushed word
		repeat (8) idle_cycle();
		check_value("almost_full_o seen high", data_t'(af_seen), 16'h0001);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/isa_pkg.sv
design/queue_pkg.sv
design/sram_1r1w.sv
design/sync_fifo.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/instr_pipe_top.sv
tb/instr_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the instruction pipeline testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=instr_pipe_sim

if ! verilator --binary --timing --timescale 1ns/1ps --top-module instr_pipe_tb \
	-f list.f -o "$SIM"; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	exit 1
fi

exit 0
